/* fetch_pkg.sv */
package fetch_pkg;

    // datapath and instruction width
    localparam int xlen = 32;

    // program store geometry
    localparam int mem_bytes     = 1024;
    localparam int mem_addr_bits = 10;

    // instruction queue entries, power of two
    localparam int queue_depth = 4;

    // rv32 major opcodes, bits [6:0]
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // decoded instruction class
    typedef enum logic [3:0] {
        op_alu_reg  = 4'd0,
        op_alu_imm  = 4'd1,
        // register op with funct7 0000001
        op_muldiv   = 4'd2,
        op_load     = 4'd3,
        op_store    = 4'd4,
        op_branch   = 4'd5,
        op_lui      = 4'd6,
        op_auipc    = 4'd7,
        op_jal      = 4'd8,
        op_jalr     = 4'd9,
        op_illegal  = 4'd10
    } op_class_e;

    // architectural register index
    typedef logic [4:0] reg_idx_t;

endpackage

/* fetch_ifs.sv */
// fetch unit to queue, one strobe per instruction
interface inst_push_if;
    import fetch_pkg::*;

    logic            valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;
    logic            full;

    modport producer (output valid, output pc, output inst, input full);
    modport buffer (input valid, input pc, input inst, output full);

endinterface

// queue head to decoder
interface inst_pop_if;
    import fetch_pkg::*;

    logic            pop;
    logic            empty;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] inst;

    modport buffer (input pop, output empty, output pc, output inst);
    modport consumer (output pop, input empty, input pc, input inst);

endinterface

/* instruction_memory.sv */
module instruction_memory (
    input  logic                              clk,
    input  logic                              load_en,
    input  logic [fetch_pkg::mem_addr_bits-1:0] load_addr,
    input  logic [fetch_pkg::xlen-1:0]        load_data,
    input  logic [fetch_pkg::mem_addr_bits-1:0] pc,
    output logic [fetch_pkg::xlen-1:0]        inst
);
    import fetch_pkg::*;

    logic [7:0] mem [mem_bytes];

    // byte addresses of the word being read, wrap at the top
    logic [mem_addr_bits-1:0] rd_a1;
    logic [mem_addr_bits-1:0] rd_a2;
    logic [mem_addr_bits-1:0] rd_a3;

    // word-aligned base of the write
    logic [mem_addr_bits-3:0] wr_word;

    // unloaded locations read back as zero
    initial begin
        for (int i = 0; i < mem_bytes; i++) begin
            mem[i] = 8'h00;
        end
    end

    assign wr_word = load_addr[mem_addr_bits-1:2];

    // msb goes to the lowest address
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[{wr_word, 2'd0}] <= load_data[31:24];
            mem[{wr_word, 2'd1}] <= load_data[23:16];
            mem[{wr_word, 2'd2}] <= load_data[15:8];
            mem[{wr_word, 2'd3}] <= load_data[7:0];
        end
    end

    assign rd_a1 = pc + mem_addr_bits'(1);
    assign rd_a2 = pc + mem_addr_bits'(2);
    assign rd_a3 = pc + mem_addr_bits'(3);

    // big-endian assembly, same cycle as pc
    assign inst = {mem[pc], mem[rd_a1], mem[rd_a2], mem[rd_a3]};

endmodule

/* fetch_unit.sv */
module fetch_unit (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                run,
    input  logic                                redirect,
    input  logic [fetch_pkg::xlen-1:0]          redirect_pc,
    output logic [fetch_pkg::mem_addr_bits-1:0] mem_pc,
    input  logic [fetch_pkg::xlen-1:0]          mem_inst,
    output logic                                flush,
    inst_push_if.producer                       push
);
    import fetch_pkg::*;

    logic [xlen-1:0]          pc;
    logic [mem_addr_bits-1:0] pc_inc;
    logic                     do_fetch;

    // memory only sees the low pc bits
    assign mem_pc = pc[mem_addr_bits-1:0];

    // next sequential pc, wraps modulo memory size
    assign pc_inc = mem_pc + mem_addr_bits'(4);

    // redirect takes the cycle, full stalls it
    assign do_fetch = run && !redirect && !push.full;

    assign flush = redirect;

    assign push.valid = do_fetch;
    assign push.pc    = pc;
    assign push.inst  = mem_inst;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (do_fetch) begin
            pc <= xlen'(pc_inc);
        end
    end

endmodule

/* inst_queue.sv */
module inst_queue (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    inst_push_if.buffer push,
    inst_pop_if.buffer  pop
);
    import fetch_pkg::*;

    // payload storage
    logic [xlen-1:0] pc_mem   [queue_depth];
    logic [xlen-1:0] inst_mem [queue_depth];

    logic [$clog2(queue_depth)-1:0]   wr_ptr;
    logic [$clog2(queue_depth)-1:0]   rd_ptr;
    logic [$clog2(queue_depth+1)-1:0] count;

    logic full;
    logic empty;
    logic do_push;
    logic do_pop;

    assign full  = (count == queue_depth);
    assign empty = (count == '0);

    // a push into a full queue is only taken alongside a pop
    assign do_push = push.valid && (!full || do_pop);
    assign do_pop  = pop.pop && !empty;

    assign push.full = full;
    assign pop.empty = empty;
    assign pop.pc    = pc_mem[rd_ptr];
    assign pop.inst  = inst_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[wr_ptr]   <= push.pc;
            inst_mem[wr_ptr] <= push.inst;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            // flush beats a push in the same cycle
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* inst_decoder.sv */
module inst_decoder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        issue,
    input  logic                        redirect,
    inst_pop_if.consumer                pop,
    output logic                        dec_valid,
    output logic [fetch_pkg::xlen-1:0]  dec_pc,
    output fetch_pkg::op_class_e        dec_op,
    output fetch_pkg::reg_idx_t         dec_rd,
    output fetch_pkg::reg_idx_t         dec_rs1,
    output fetch_pkg::reg_idx_t         dec_rs2,
    output logic [fetch_pkg::xlen-1:0]  dec_imm
);
    import fetch_pkg::*;

    logic [xlen-1:0] inst;
    logic [6:0]      opcode;
    logic [6:0]      funct7;
    op_class_e       op_class;
    logic [xlen-1:0] imm;
    logic            take;

    assign inst   = pop.inst;
    assign opcode = inst[6:0];
    assign funct7 = inst[31:25];

    // a redirect in the same cycle discards the issue
    assign take    = issue && !redirect && !pop.empty;
    assign pop.pop = take;

    // class and sign-extended immediate of the head entry
    always_comb begin
        op_class = op_illegal;
        imm      = '0;
        case (opcode)
            opc_op: begin
                op_class = (funct7 == 7'b0000001) ? op_muldiv : op_alu_reg;
            end
            opc_op_imm: begin
                op_class = op_alu_imm;
                imm      = {{20{inst[31]}}, inst[31:20]};
            end
            opc_load: begin
                op_class = op_load;
                imm      = {{20{inst[31]}}, inst[31:20]};
            end
            opc_jalr: begin
                op_class = op_jalr;
                imm      = {{20{inst[31]}}, inst[31:20]};
            end
            opc_store: begin
                op_class = op_store;
                imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            opc_branch: begin
                op_class = op_branch;
                // B format, bit 0 always zero
                imm      = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                            inst[11:8], 1'b0};
            end
            opc_lui: begin
                op_class = op_lui;
                imm      = {inst[31:12], 12'b0};
            end
            opc_auipc: begin
                op_class = op_auipc;
                imm      = {inst[31:12], 12'b0};
            end
            opc_jal: begin
                op_class = op_jal;
                imm      = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                            inst[30:21], 1'b0};
            end
            default: begin
                op_class = op_illegal;
                imm      = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= take;
        end
    end

    // result fields, meaningful only with dec_valid
    always_ff @(posedge clk) begin
        if (take) begin
            dec_pc  <= pop.pc;
            dec_op  <= op_class;
            dec_rd  <= inst[11:7];
            dec_rs1 <= inst[19:15];
            dec_rs2 <= inst[24:20];
            dec_imm <= imm;
        end
    end

endmodule

/* fetch_decode_top.sv */
module fetch_decode_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                load_en,
    input  logic [fetch_pkg::mem_addr_bits-1:0] load_addr,
    input  logic [fetch_pkg::xlen-1:0]          load_data,
    input  logic                                run,
    input  logic                                redirect,
    input  logic [fetch_pkg::xlen-1:0]          redirect_pc,
    input  logic                                issue,
    output logic                                dec_valid,
    output logic [fetch_pkg::xlen-1:0]          dec_pc,
    output fetch_pkg::op_class_e                dec_op,
    output fetch_pkg::reg_idx_t                 dec_rd,
    output fetch_pkg::reg_idx_t                 dec_rs1,
    output fetch_pkg::reg_idx_t                 dec_rs2,
    output logic [fetch_pkg::xlen-1:0]          dec_imm
);
    import fetch_pkg::*;

    logic [mem_addr_bits-1:0] mem_pc;
    logic [xlen-1:0]          mem_inst;
    logic                     flush;

    inst_push_if push_if ();
    inst_pop_if  pop_if ();

    instruction_memory instruction_memory_inst (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .pc        (mem_pc),
        .inst      (mem_inst)
    );

    fetch_unit fetch_unit_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_pc      (mem_pc),
        .mem_inst    (mem_inst),
        .flush       (flush),
        .push        (push_if.producer)
    );

    // small buffer between fetch and decode
    inst_queue inst_queue_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .push  (push_if.buffer),
        .pop   (pop_if.buffer)
    );

    inst_decoder inst_decoder_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue     (issue),
        .redirect  (redirect),
        .pop       (pop_if.consumer),
        .dec_valid (dec_valid),
        .dec_pc    (dec_pc),
        .dec_op    (dec_op),
        .dec_rd    (dec_rd),
        .dec_rs1   (dec_rs1),
        .dec_rs2   (dec_rs2),
        .dec_imm   (dec_imm)
    );

endmodule

/* tb_fetch_decode.sv */
module tb_fetch_decode;
    timeunit 1ns;
    timeprecision 1ps;
    import fetch_pkg::*;

    logic                     clk;
    logic                     rst_n;
    logic                     load_en;
    logic [mem_addr_bits-1:0] load_addr;
    logic [xlen-1:0]          load_data;
    logic                     run;
    logic                     redirect;
    logic [xlen-1:0]          redirect_pc;
    logic                     issue;
    logic                     dec_valid;
    logic [xlen-1:0]          dec_pc;
    op_class_e                dec_op;
    reg_idx_t                 dec_rd;
    reg_idx_t                 dec_rs1;
    reg_idx_t                 dec_rs2;
    logic [xlen-1:0]          dec_imm;

    // records from the vectors file
    logic [31:0] ld_addr_q[$];
    logic [31:0] ld_data_q[$];
    logic [31:0] e_pc[$];
    logic [3:0]  e_op[$];
    logic [4:0]  e_rd[$];
    logic [4:0]  e_rs1[$];
    logic [4:0]  e_rs2[$];
    logic [31:0] e_imm[$];
    logic [31:0] redir_target[$];
    // expected-result count reached once the segment after each redirect is done
    int          redir_limit[$];

    int          exp_idx = 0;
    int          exp_limit = 0;
    int          redir_ptr = 0;
    int          first_limit = 0;
    int          cycles = 0;
    int          cycle_limit = 1000000;
    logic        running = 1'b0;
    logic [31:0] lfsr = 32'h24b0_fc3e;

    fetch_decode_top fetch_decode_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois form, one step per random bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        stop_with_failure($sformatf("error %s expected %h actual %h", name, exp_v, act_v));
    endtask

    task automatic read_vectors();
        int    fd;
        int    code;
        string kind;
        string rest;
        logic [31:0] a;
        logic [31:0] w;
        int    op;
        int    rd;
        int    rs1;
        int    rs2;
        fd = $fopen("fetch_decode_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_failure("cannot open fetch_decode_vectors.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %s", kind);
            if (code != 1) begin
                break;
            end
            if (kind == "#") begin
                code = $fgets(rest, fd);
            end else if (kind == "L") begin
                code = $fscanf(fd, " %h %h", a, w);
                ld_addr_q.push_back(a);
                ld_data_q.push_back(w);
            end else if (kind == "R") begin
                code = $fscanf(fd, " %h", a);
                redir_target.push_back(a);
                redir_limit.push_back(e_pc.size());
            end else if (kind == "E") begin
                code = $fscanf(fd, " %h %d %d %d %d %h", a, op, rd, rs1, rs2, w);
                e_pc.push_back(a);
                e_op.push_back(op[3:0]);
                e_rd.push_back(rd[4:0]);
                e_rs1.push_back(rs1[4:0]);
                e_rs2.push_back(rs2[4:0]);
                e_imm.push_back(w);
            end else begin
                stop_with_failure($sformatf("unknown record kind %s in vectors", kind));
            end
        end
        $fclose(fd);
        // shift limits so each redirect enables the segment that follows it
        first_limit = (redir_limit.size() > 0) ? redir_limit[0] : e_pc.size();
        for (int i = 0; i < redir_limit.size(); i++) begin
            redir_limit[i] = (i + 1 < redir_limit.size()) ? redir_limit[i + 1] : e_pc.size();
        end
    endtask

    // issue and redirect while running
    always @(negedge clk) begin
        if (running) begin
            lfsr     = lfsr_step(lfsr);
            redirect = 1'b0;
            issue    = 1'b0;
            if (redir_ptr < redir_target.size() && exp_idx == exp_limit && !dec_valid) begin
                redirect    = 1'b1;
                redirect_pc = redir_target[redir_ptr];
                exp_limit   = redir_limit[redir_ptr];
                redir_ptr++;
            end else if (exp_idx + int'(dec_valid) < exp_limit) begin
                issue = lfsr[0];
            end
        end
    end

    // result monitor
    always @(posedge clk) begin
        if (rst_n && dec_valid) begin
            assert (exp_idx < exp_limit)
                else stop_with_failure("dec_valid seen while no result was expected");
            assert (dec_pc === e_pc[exp_idx])
                else report_mismatch($sformatf("rec%0d pc", exp_idx), e_pc[exp_idx], dec_pc);
            assert (4'(dec_op) === e_op[exp_idx])
                else report_mismatch($sformatf("rec%0d op", exp_idx),
                                     32'(e_op[exp_idx]), 32'(dec_op));
            assert (dec_rd === e_rd[exp_idx])
                else report_mismatch($sformatf("rec%0d rd", exp_idx),
                                     32'(e_rd[exp_idx]), 32'(dec_rd));
            assert (dec_rs1 === e_rs1[exp_idx])
                else report_mismatch($sformatf("rec%0d rs1", exp_idx),
                                     32'(e_rs1[exp_idx]), 32'(dec_rs1));
            assert (dec_rs2 === e_rs2[exp_idx])
                else report_mismatch($sformatf("rec%0d rs2", exp_idx),
                                     32'(e_rs2[exp_idx]), 32'(dec_rs2));
            assert (dec_imm === e_imm[exp_idx])
                else report_mismatch($sformatf("rec%0d imm", exp_idx), e_imm[exp_idx], dec_imm);
            exp_idx++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d results matched", cycles, exp_idx);
            $display(">>> FAIL");
            $fatal(1);
        end
    end

    initial begin
        rst_n       = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        run         = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        issue       = 1'b0;
        read_vectors();
        cycle_limit = 40 * (ld_addr_q.size() + redir_target.size() + e_pc.size()) + 200;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // program load, run stays low
        for (int i = 0; i < ld_addr_q.size(); i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = ld_addr_q[i][mem_addr_bits-1:0];
            load_data = ld_data_q[i];
        end
        @(negedge clk);
        load_en = 1'b0;

        // idle, issue strobes with nothing fetched
        repeat (20) begin
            @(negedge clk);
            lfsr  = lfsr_step(lfsr);
            issue = lfsr[0];
        end
        @(negedge clk);
        issue = 1'b0;
        repeat (3) @(negedge clk);

        // driver takes over from the next falling edge
        @(posedge clk);
        exp_limit = first_limit;
        running   = 1'b1;
        @(negedge clk);
        run = 1'b1;
        while (exp_idx < e_pc.size() || redir_ptr < redir_target.size()) begin
            @(negedge clk);
        end
        repeat (5) @(negedge clk);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* vlog.f */
fetch_pkg.sv
fetch_ifs.sv
instruction_memory.sv
fetch_unit.sv
inst_queue.sv
inst_decoder.sv
fetch_decode_top.sv
tb_fetch_decode.sv

/* Bender.yml */
package:
  name: fetch_decode

sources:
  - fetch_pkg.sv
  - fetch_ifs.sv
  - instruction_memory.sv
  - fetch_unit.sv
  - inst_queue.sv
  - inst_decoder.sv
  - fetch_decode_top.sv
  - target: simulation
    files:
      - tb_fetch_decode.sv

/* fetch_decode_vectors.txt */
# L byte_addr(hex) word(hex) | R target_pc(hex)
# E pc(hex) op_class(dec) rd(dec) rs1(dec) rs2(dec) imm(hex)
L 000 FFF00093
L 004 022081B3
L 008 0211C233
L 00C 003242B3
L 010 00812303
L 014 FC629CE3
L 018 406283B3
L 01C 0553E413
L 020 123454B7
L 024 00001517
L 028 004480E7
L 02C 025275B3
L 030 00208633
L 034 06460693
L 038 FFC6A703
L 03C 00D777B3
L 040 00379813
L 044 00000463
L 048 02F818B3
L 04C 4108D933
L 050 00812623
L 054 FADFF0EF
E 00000000 1 1 0 31 FFFFFFFF
E 00000004 2 3 1 2 00000000
E 00000008 2 4 3 1 00000000
E 0000000C 0 5 4 3 00000000
E 00000010 3 6 2 8 00000008
E 00000014 5 25 5 6 FFFFFFD8
E 00000018 0 7 5 6 00000000
E 0000001C 1 8 7 21 00000055
E 00000020 6 9 8 3 12345000
E 00000024 7 10 0 0 00001000
E 00000028 9 1 9 4 00000004
E 0000002C 2 11 4 5 00000000
E 00000030 0 12 1 2 00000000
E 00000034 1 13 12 4 00000064
E 00000038 3 14 13 28 FFFFFFFC
E 0000003C 0 15 14 13 00000000
E 00000040 1 16 15 3 00000003
E 00000044 5 8 0 0 00000008
E 00000048 2 17 16 15 00000000
E 0000004C 0 18 17 16 00000000
E 00000050 4 12 2 8 0000000C
E 00000054 8 1 31 13 FFFFFFAC
E 00000058 10 0 0 0 00000000
R 00000030
E 00000030 0 12 1 2 00000000
E 00000034 1 13 12 4 00000064
E 00000038 3 14 13 28 FFFFFFFC
R 00000000
E 00000000 1 1 0 31 FFFFFFFF
E 00000004 2 3 1 2 00000000
